// File: verilog/i2c_target_pkg.sv
package i2c_target_pkg;

    // samples a line must hold before its level is accepted
    localparam int DEBOUNCE_LEN = 10;

    // bus address and register map
    localparam logic [6:0] TARGET_ADDR = 7'h50;
    localparam int NUM_WORDS = 4;
    localparam logic [7:0] RO_BASE = 8'h08;
    localparam logic [3:0][7:0] RO_VALUES = {8'h40, 8'h30, 8'h20, 8'h10};
    localparam logic [NUM_WORDS-1:0][15:0] WORD_RESET =
        {16'h0000, 16'h0000, 16'h031d, 16'h8095};
    localparam logic [7:0] UNMAPPED_VALUE = 8'hFF;
    localparam int CONFIG_WORD = 1;

    // conditioned bus activity, one pulse per event
    typedef struct packed {
        logic scl_rise;
        logic scl_fall;
        logic start;
        logic stop;
        logic sda_level;
    } line_events_t;

    // controller to byte engine
    typedef struct packed {
        logic       ack_en;
        logic       tx_load;
        logic [7:0] tx_byte;
    } byte_cmd_t;

    // byte engine to controller
    typedef struct packed {
        logic       rx_valid;
        logic [7:0] rx_byte;
        logic       tx_done;
        logic       master_ack;
    } byte_status_t;

    // controller to register file
    typedef struct packed {
        logic       rd;
        logic       wr;
        logic [7:0] addr;
        logic [7:0] wdata;
    } reg_access_t;

    // bit layout of word 1
    typedef struct packed {
        logic [4:0] rows_delay;
        logic [2:0] spare_hi;
        logic [1:0] mclk_mode;
        logic [3:0] spare_lo;
        logic       idle_mode;
        logic       mclk_speed;
    } config_fields_t;

    // written as bytes over the bus, read as fields by the host logic
    typedef union packed {
        logic [15:0]    raw;
        config_fields_t fields;
    } config_word_u;

endpackage

// File: verilog/i2c_line_conditioner.sv
`timescale 1ns/1ps

module i2c_line_conditioner
(
    input  logic                         CLOCK,
    input  logic                         RESET,
    input  logic                         scl,
    input  logic                         sda,
    output i2c_target_pkg::line_events_t events
);

    localparam int LEN = i2c_target_pkg::DEBOUNCE_LEN;

    // index 0 is scl, index 1 is sda
    logic [1:0]          raw;
    logic [1:0][LEN-1:0] history;
    logic [1:0]          level;
    logic [1:0]          level_prev;
    logic                scl_high;
    logic                sda_rise;
    logic                sda_fall;

    i2c_target_pkg::line_events_t next_events;

    assign raw = {sda, scl};

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            history    <= '1;
            level      <= '1;
            level_prev <= '1;
        end
        else
        begin
            for (int i = 0; i < 2; i++)
            begin
                history[i] <= {history[i][LEN-2:0], raw[i]};
                // level moves only once the whole history agrees
                if (&history[i])
                begin
                    level[i] <= 1'b1;
                end
                else if (~|history[i])
                begin
                    level[i] <= 1'b0;
                end
            end
            level_prev <= level;
        end
    end

    always_comb
    begin
        scl_high = level[0] & level_prev[0];
        sda_rise = level[1] & ~level_prev[1];
        sda_fall = ~level[1] & level_prev[1];

        next_events.scl_rise  = level[0] & ~level_prev[0];
        next_events.scl_fall  = ~level[0] & level_prev[0];
        next_events.start     = scl_high & sda_fall;
        next_events.stop      = scl_high & sda_rise;
        next_events.sda_level = level[1];
    end

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            events <= '{scl_rise: 1'b0, scl_fall: 1'b0, start: 1'b0, stop: 1'b0,
                        sda_level: 1'b1};
        end
        else
        begin
            events <= next_events;
        end
    end

    // sda and scl must settle apart so start and stop stay unambiguous
    assert property (@(posedge CLOCK) disable iff (RESET)
        !((level[0] != level_prev[0]) && (level[1] != level_prev[1])))
        else $error("scl and sda settled in the same cycle");

endmodule

// File: verilog/i2c_byte_engine.sv
`timescale 1ns/1ps

module i2c_byte_engine
(
    input  logic                         CLOCK,
    input  logic                         RESET,
    input  i2c_target_pkg::line_events_t events,
    input  i2c_target_pkg::byte_cmd_t    cmd,
    output i2c_target_pkg::byte_status_t status,
    output logic                         sda_drive_low
);

    typedef enum logic [2:0] {
        S_RX,
        S_ACK_WAIT,
        S_ACK,
        S_TX,
        S_MACK
    } state_t;

    state_t     state;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic       tx_pending;
    logic       rx_valid;
    logic       tx_done;
    logic       master_ack;
    logic       scl_high;

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            state         <= S_RX;
            bit_cnt       <= '0;
            tx_pending    <= 1'b0;
            rx_valid      <= 1'b0;
            tx_done       <= 1'b0;
            master_ack    <= 1'b0;
            sda_drive_low <= 1'b0;
            scl_high      <= 1'b1;
        end
        else
        begin
            rx_valid <= 1'b0;
            tx_done  <= 1'b0;
            if (events.scl_rise)
            begin
                scl_high <= 1'b1;
            end
            else if (events.scl_fall)
            begin
                scl_high <= 1'b0;
            end

            if (events.start || events.stop)
            begin
                state         <= S_RX;
                bit_cnt       <= '0;
                tx_pending    <= 1'b0;
                sda_drive_low <= 1'b0;
            end
            else
            begin
                // loaded during the address ACK, sent when the slot closes
                if (cmd.tx_load)
                begin
                    shift      <= cmd.tx_byte;
                    tx_pending <= 1'b1;
                end
                case (state)
                    S_RX:
                    begin
                        if (events.scl_rise)
                        begin
                            shift   <= {shift[6:0], events.sda_level};
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                            begin
                                rx_valid <= 1'b1;
                                state    <= S_ACK_WAIT;
                            end
                        end
                    end
                    S_ACK_WAIT:
                    begin
                        if (events.scl_fall)
                        begin
                            sda_drive_low <= cmd.ack_en;
                            state         <= S_ACK;
                        end
                    end
                    S_ACK:
                    begin
                        if (events.scl_fall)
                        begin
                            bit_cnt <= '0;
                            if (tx_pending)
                            begin
                                sda_drive_low <= ~shift[7];
                                tx_pending    <= 1'b0;
                                state         <= S_TX;
                            end
                            else
                            begin
                                sda_drive_low <= 1'b0;
                                state         <= S_RX;
                            end
                        end
                    end
                    S_TX:
                    begin
                        if (events.scl_fall)
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                            begin
                                // release for the master's ACK bit
                                sda_drive_low <= 1'b0;
                                state         <= S_MACK;
                            end
                            else
                            begin
                                shift         <= {shift[6:0], 1'b0};
                                sda_drive_low <= ~shift[6];
                            end
                        end
                    end
                    S_MACK:
                    begin
                        if (events.scl_rise)
                        begin
                            master_ack <= ~events.sda_level;
                            tx_done    <= 1'b1;
                            state      <= S_RX;
                        end
                    end
                    default:
                    begin
                        state <= S_RX;
                    end
                endcase
            end
        end
    end

    always_comb
    begin
        status.rx_valid   = rx_valid;
        status.rx_byte    = shift;
        status.tx_done    = tx_done;
        status.master_ack = master_ack;
    end

    // the target moves sda only while scl is low, so it never fakes a start or stop
    assert property (@(posedge CLOCK) disable iff (RESET)
        $changed(sda_drive_low) |-> !scl_high)
        else $error("sda_drive_low changed while scl was high");

endmodule

// File: verilog/i2c_transaction_ctrl.sv
`timescale 1ns/1ps

module i2c_transaction_ctrl
(
    input  logic                         CLOCK,
    input  logic                         RESET,
    input  i2c_target_pkg::line_events_t events,
    input  i2c_target_pkg::byte_status_t status,
    output i2c_target_pkg::byte_cmd_t    cmd,
    input  logic [7:0]                   rd_data,
    output i2c_target_pkg::reg_access_t  access
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_PTR,
        S_WDATA,
        S_RDATA,
        S_WAIT_STOP
    } state_t;

    state_t     state;
    logic [7:0] pointer;
    logic [7:0] wdata;
    logic       ack_en;
    logic       tx_load;
    logic       rd;
    logic       wr;
    logic       addr_match;

    // 7-bit address, the last bit is the direction
    assign addr_match = (status.rx_byte[7:1] == i2c_target_pkg::TARGET_ADDR);

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            pointer <= '0;
            ack_en  <= 1'b0;
            tx_load <= 1'b0;
            rd      <= 1'b0;
            wr      <= 1'b0;
        end
        else
        begin
            rd      <= 1'b0;
            wr      <= 1'b0;
            // read data is on rd_data one cycle after rd
            tx_load <= rd;

            if (events.stop)
            begin
                state  <= S_IDLE;
                ack_en <= 1'b0;
            end
            else if (events.start)
            begin
                state  <= S_ADDR;
                ack_en <= 1'b0;
            end
            else
            begin
                case (state)
                    S_ADDR:
                    begin
                        if (status.rx_valid)
                        begin
                            if (!addr_match)
                            begin
                                state <= S_WAIT_STOP;
                            end
                            else if (status.rx_byte[0])
                            begin
                                ack_en <= 1'b1;
                                rd     <= 1'b1;
                                state  <= S_RDATA;
                            end
                            else
                            begin
                                ack_en <= 1'b1;
                                state  <= S_PTR;
                            end
                        end
                    end
                    S_PTR:
                    begin
                        if (status.rx_valid)
                        begin
                            pointer <= status.rx_byte;
                            state   <= S_WDATA;
                        end
                    end
                    S_WDATA:
                    begin
                        if (status.rx_valid)
                        begin
                            wr    <= 1'b1;
                            wdata <= status.rx_byte;
                            state <= S_WAIT_STOP;
                        end
                    end
                    S_RDATA:
                    begin
                        if (status.tx_done)
                        begin
                            ack_en <= 1'b0;
                            state  <= S_WAIT_STOP;
                        end
                    end
                    S_WAIT_STOP:
                    begin
                        // extra bytes of a burst are not acknowledged
                        if (status.rx_valid)
                        begin
                            ack_en <= 1'b0;
                        end
                    end
                    default:
                    begin
                        // idle until a start
                        state <= S_IDLE;
                    end
                endcase
            end
        end
    end

    always_comb
    begin
        cmd.ack_en   = ack_en;
        cmd.tx_load  = tx_load;
        cmd.tx_byte  = rd_data;
        access.rd    = rd;
        access.wr    = wr;
        access.addr  = pointer;
        access.wdata = wdata;
    end

    // engine and controller agree on the direction of the current byte
    assert property (@(posedge CLOCK) disable iff (RESET)
        status.rx_valid |-> (state != S_RDATA))
        else $error("byte received while the read byte was being sent");

    // reads are single bytes, so the master ends each one with a NACK
    assert property (@(posedge CLOCK) disable iff (RESET)
        status.tx_done |-> !status.master_ack)
        else $error("master acknowledged a read byte and asked for a burst");

endmodule

// File: verilog/i2c_register_file.sv
`timescale 1ns/1ps

module i2c_register_file
(
    input  logic                        CLOCK,
    input  logic                        RESET,
    input  i2c_target_pkg::reg_access_t access,
    output logic [7:0]                  rd_data,
    input  logic                        rd_en,
    input  logic [2:0]                  side_addr,
    output logic [15:0]                 dat_out,
    output logic                        mclk_speed,
    output logic                        idle_mode,
    output logic [1:0]                  mclk_mode,
    output logic [4:0]                  rows_delay
);

    // two bus bytes per word
    localparam logic [7:0] WORD_BYTES = 8'(2 * i2c_target_pkg::NUM_WORDS);

    logic [i2c_target_pkg::NUM_WORDS-1:0][15:0] words;
    logic [1:0]                                 word_sel;
    logic [7:0]                                 ro_offset;

    i2c_target_pkg::config_word_u config_word;

    assign word_sel  = access.addr[2:1];
    assign ro_offset = access.addr - i2c_target_pkg::RO_BASE;

    // even address is the high byte, odd the low byte
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            words <= i2c_target_pkg::WORD_RESET;
        end
        else if (access.wr && access.addr < WORD_BYTES)
        begin
            if (access.addr[0])
            begin
                words[word_sel][7:0] <= access.wdata;
            end
            else
            begin
                words[word_sel][15:8] <= access.wdata;
            end
        end
    end

    always_ff @(posedge CLOCK)
    begin
        if (access.rd)
        begin
            if (access.addr < WORD_BYTES)
            begin
                rd_data <= access.addr[0] ? words[word_sel][7:0] : words[word_sel][15:8];
            end
            else if (ro_offset < 8'd4)
            begin
                rd_data <= i2c_target_pkg::RO_VALUES[ro_offset[1:0]];
            end
            else
            begin
                rd_data <= i2c_target_pkg::UNMAPPED_VALUE;
            end
        end
    end

    // side port, zero above the last word
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            dat_out <= '0;
        end
        else if (rd_en)
        begin
            if (side_addr < 3'(i2c_target_pkg::NUM_WORDS))
            begin
                dat_out <= words[side_addr[1:0]];
            end
            else
            begin
                dat_out <= '0;
            end
        end
    end

    assign config_word.raw = words[i2c_target_pkg::CONFIG_WORD];
    assign mclk_speed      = config_word.fields.mclk_speed;
    assign idle_mode       = config_word.fields.idle_mode;
    assign mclk_mode       = config_word.fields.mclk_mode;
    assign rows_delay      = config_word.fields.rows_delay;

endmodule

// File: verilog/i2c_target_top.sv
`timescale 1ns/1ps

module i2c_target_top
(
    input  logic        CLOCK,
    input  logic        RESET,
    input  logic        scl,
    input  logic        sda,
    output logic        sda_drive_low,
    input  logic        rd_en,
    input  logic [2:0]  side_addr,
    output logic [15:0] dat_out,
    output logic        mclk_speed,
    output logic        idle_mode,
    output logic [1:0]  mclk_mode,
    output logic [4:0]  rows_delay
);

    i2c_target_pkg::line_events_t events;
    i2c_target_pkg::byte_cmd_t    cmd;
    i2c_target_pkg::byte_status_t status;
    i2c_target_pkg::reg_access_t  access;
    logic [7:0]                   rd_data;

    i2c_line_conditioner u_line_conditioner
    (
        .CLOCK  (CLOCK),
        .RESET  (RESET),
        .scl    (scl),
        .sda    (sda),
        .events (events)
    );

    i2c_byte_engine u_byte_engine
    (
        .CLOCK         (CLOCK),
        .RESET         (RESET),
        .events        (events),
        .cmd           (cmd),
        .status        (status),
        .sda_drive_low (sda_drive_low)
    );

    i2c_transaction_ctrl u_transaction_ctrl
    (
        .CLOCK   (CLOCK),
        .RESET   (RESET),
        .events  (events),
        .status  (status),
        .cmd     (cmd),
        .rd_data (rd_data),
        .access  (access)
    );

    i2c_register_file u_register_file
    (
        .CLOCK      (CLOCK),
        .RESET      (RESET),
        .access     (access),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .side_addr  (side_addr),
        .dat_out    (dat_out),
        .mclk_speed (mclk_speed),
        .idle_mode  (idle_mode),
        .mclk_mode  (mclk_mode),
        .rows_delay (rows_delay)
    );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic CLOCK,
    output logic RESET
);

    localparam int RESET_CYCLES = 10;

    // 40 ns period
    initial
    begin
        CLOCK = 1'b0;
        forever #20 CLOCK = ~CLOCK;
    end

    initial
    begin
        RESET = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLOCK);
        #2;
        RESET = 1'b0;
    end

endmodule

// File: verif/tb_i2c_target.sv
`timescale 1ns/1ps

module tb_i2c_target;

    // one quarter of an I2C bit, in clock cycles
    localparam int QUARTER = 40;
    // roughly twice the cycles the tests need
    localparam int CYCLE_LIMIT = 400000;
    localparam logic [31:0] SEED = 32'h0a81_6ab4;
    localparam logic [6:0] DEV_ADDR = 7'h50;

    logic        CLOCK;
    logic        RESET;
    logic        scl;
    logic        sda_master;
    logic        sda_bus;
    logic        sda_drive_low;
    logic        rd_en;
    logic [2:0]  side_addr;
    logic [15:0] dat_out;
    logic        mclk_speed;
    logic        idle_mode;
    logic [1:0]  mclk_mode;
    logic [4:0]  rows_delay;

    // expected contents of the four read/write words
    logic [15:0] model_words [4];
    int          cycles = 0;

    // open-drain line, either side can pull it low
    assign sda_bus = sda_master & ~sda_drive_low;

    tb_clock_gen u_clock_gen
    (
        .CLOCK (CLOCK),
        .RESET (RESET)
    );

    i2c_target_top u_i2c_target_top
    (
        .CLOCK         (CLOCK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda_bus),
        .sda_drive_low (sda_drive_low),
        .rd_en         (rd_en),
        .side_addr     (side_addr),
        .dat_out       (dat_out),
        .mclk_speed    (mclk_speed),
        .idle_mode     (idle_mode),
        .mclk_mode     (mclk_mode),
        .rows_delay    (rows_delay)
    );

    // answer of a bus read at a byte address
    function automatic logic [7:0] expected_byte(input logic [7:0] addr);
        logic [15:0] sel_word;
        sel_word = model_words[addr[2:1]];
        if (addr < 8'h08)
        begin
            return addr[0] ? sel_word[7:0] : sel_word[15:8];
        end
        case (addr)
            8'h08: return 8'h10;
            8'h09: return 8'h20;
            8'h0a: return 8'h30;
            8'h0b: return 8'h40;
            default: return 8'hff;
        endcase
    endfunction

    // {rows_delay, mclk_mode, idle_mode, mclk_speed}
    function automatic logic [8:0] expected_config(input logic [15:0] word);
        return {word[15:11], word[7:6], word[1], word[0]};
    endfunction

    function automatic logic [15:0] expected_side(input logic [2:0] addr);
        if (addr < 3'd4)
        begin
            return model_words[addr[1:0]];
        end
        return 16'h0000;
    endfunction

    task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
        if (addr < 8'h08)
        begin
            if (addr[0])
            begin
                model_words[addr[2:1]][7:0] = data;
            end
            else
            begin
                model_words[addr[2:1]][15:8] = data;
            end
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected)
        begin
            fail_run($sformatf("mismatch at %0d ns: %s is 0x%h, expected 0x%h",
                               $time, name, actual, expected));
        end
    endtask

    // lands 2 ns after a rising edge
    task automatic tick(input int n);
        repeat (n) @(posedge CLOCK);
        #2;
    endtask

    // serves a fresh start and a repeated start
    task automatic bus_start();
        sda_master = 1'b1;
        tick(QUARTER);
        scl = 1'b1;
        tick(QUARTER);
        sda_master = 1'b0;
        tick(QUARTER);
        scl = 1'b0;
        tick(QUARTER);
    endtask

    task automatic bus_stop();
        sda_master = 1'b0;
        tick(QUARTER);
        scl = 1'b1;
        tick(QUARTER);
        sda_master = 1'b1;
        tick(QUARTER);
    endtask

    // one scl pulse, line sampled in the middle of the high phase
    task automatic clock_bit(input logic value, output logic seen);
        sda_master = value;
        tick(QUARTER);
        scl = 1'b1;
        tick(QUARTER);
        seen = sda_bus;
        tick(QUARTER);
        scl = 1'b0;
        tick(QUARTER);
    endtask

    task automatic send_byte(input logic [7:0] value, output logic acked);
        logic seen;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(value[i], seen);
        end
        clock_bit(1'b1, seen);
        acked = ~seen;
    endtask

    task automatic send_acked(input logic [7:0] value, input string what);
        logic acked;
        send_byte(value, acked);
        if (!acked)
        begin
            fail_run($sformatf("no ACK from the target for the %s byte 0x%h at %0d ns",
                               what, value, $time));
        end
    endtask

    // master NACKs the byte
    task automatic receive_byte(output logic [7:0] value);
        logic seen;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, seen);
            value[i] = seen;
        end
        clock_bit(1'b1, seen);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        bus_start();
        send_acked({DEV_ADDR, 1'b0}, "address");
        send_acked(addr, "pointer");
        send_acked(data, "data");
        bus_stop();
        model_write(addr, data);
    endtask

    task automatic bus_read(input logic [7:0] addr, input logic repeated);
        logic [7:0] value;
        bus_start();
        send_acked({DEV_ADDR, 1'b0}, "address");
        send_acked(addr, "pointer");
        if (!repeated)
        begin
            bus_stop();
        end
        bus_start();
        send_acked({DEV_ADDR, 1'b1}, "read address");
        receive_byte(value);
        bus_stop();
        check_value($sformatf("read data at 0x%h", addr), {8'h00, value},
                    {8'h00, expected_byte(addr)});
    endtask

    // the target must leave every ACK slot high
    task automatic bus_wrong_address(input logic [6:0] dev);
        logic       acked;
        logic [7:0] value;
        value = {dev, 1'b0};
        bus_start();
        for (int n = 0; n < 3; n++)
        begin
            send_byte(value, acked);
            if (acked)
            begin
                fail_run($sformatf("target acknowledged byte %0d sent to wrong address 0x%h",
                                   n, dev));
            end
            value = 8'($urandom_range(255, 0));
        end
        bus_stop();
    endtask

    task automatic side_read(input logic [2:0] addr);
        side_addr = addr;
        rd_en = 1'b1;
        tick(1);
        rd_en = 1'b0;
        check_value($sformatf("dat_out for side_addr %0d", addr), dat_out,
                    expected_side(addr));
    endtask

    task automatic check_config();
        check_value("{rows_delay, mclk_mode, idle_mode, mclk_speed}",
                    {7'd0, rows_delay, mclk_mode, idle_mode, mclk_speed},
                    {7'd0, expected_config(model_words[1])});
    endtask

    always @(posedge CLOCK)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            fail_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    initial
    begin
        logic [7:0]  addr;
        logic [7:0]  data;
        logic [6:0]  dev;
        logic [15:0] held;

        void'($urandom(SEED));
        scl = 1'b1;
        sda_master = 1'b1;
        rd_en = 1'b0;
        side_addr = 3'd0;
        model_words[0] = 16'h8095;
        model_words[1] = 16'h031d;
        model_words[2] = 16'h0000;
        model_words[3] = 16'h0000;

        wait (RESET == 1'b0);
        tick(4);

        // state right after reset
        check_value("dat_out", dat_out, 16'h0000);
        check_value("sda_drive_low", {15'd0, sda_drive_low}, 16'h0000);
        check_config();

        // bus writes seen through the side port
        for (int i = 0; i < 8; i++)
        begin
            addr = 8'($urandom_range(7, 0));
            data = 8'($urandom_range(255, 0));
            bus_write(addr, data);
            side_read(addr[3:1]);
        end

        // read/write bytes, read-only bytes and unmapped addresses
        for (int i = 0; i < 12; i++)
        begin
            case (i % 3)
                0: addr = 8'($urandom_range(7, 0));
                1: addr = 8'($urandom_range(11, 8));
                default: addr = 8'($urandom_range(255, 12));
            endcase
            bus_read(addr, (i % 2) == 0);
        end

        for (int i = 0; i < 4; i++)
        begin
            do
            begin
                dev = 7'($urandom_range(127, 0));
            end
            while (dev == DEV_ADDR);
            bus_wrong_address(dev);
        end
        for (int a = 0; a < 4; a++)
        begin
            side_read(3'(a));
        end

        // word 1 drives the configuration outputs
        for (int i = 0; i < 3; i++)
        begin
            bus_write(8'h02, 8'($urandom_range(255, 0)));
            check_config();
            bus_write(8'h03, 8'($urandom_range(255, 0)));
            check_config();
        end

        // nothing above word 3 on the side port
        for (int a = 4; a < 8; a++)
        begin
            side_read(3'(a));
        end

        // dat_out must hold while rd_en is low
        side_read(3'd1);
        held = model_words[1];
        side_addr = 3'd0;
        bus_write(8'h02, ~model_words[1][15:8]);
        tick(QUARTER);
        check_value("dat_out with rd_en low", dat_out, held);

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: vlog.f
verilog/i2c_target_pkg.sv
verilog/i2c_line_conditioner.sv
verilog/i2c_byte_engine.sv
verilog/i2c_transaction_ctrl.sv
verilog/i2c_register_file.sv
verilog/i2c_target_top.sv
verif/tb_clock_gen.sv
verif/tb_i2c_target.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_i2c_target
FILELIST  := vlog.f
BUILD_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the simulator exits non-zero on $fatal, which fails this target
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
